// File: cache_pkg.sv
/*
 * cache bus package
 * word, lane-enable and counter types, bus structs and controller states
 */
package cache_pkg;

    // bus word, used for both addresses and data
    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] byte_en_t;

    // miss and conflict counters
    typedef logic [31:0] count_t;

    // request side of a busy-level bus
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    // response side, transfer completes when busy is low
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

    // controller states
    typedef enum logic [2:0] {
        INIT,
        LOOKUP,
        WRITEBACK,
        FETCH,
        FLUSH
    } cache_state_t;

endpackage

// File: line_array.sv
/*
 * cache line array
 * tag, valid, dirty and data per set with lookup and one write per cycle
 */
`timescale 1ns/1ps

module line_array import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2
) (
    input  logic     CLK,
    input  logic     nRST,
    input  word_t    lookup_addr,
    output logic     hit,
    output logic     line_valid,
    output logic     line_dirty,
    output word_t    victim_addr,
    output word_t    hit_word,
    input  logic     wr_data_en,
    input  logic     wr_commit,
    input  logic     wr_inval,
    input  word_t    wr_addr,
    input  word_t    wr_word,
    input  byte_en_t wr_byte_en
);

    localparam int N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int WORD_BITS = $clog2(BLOCK_SIZE);
    localparam int SET_BITS  = $clog2(N_SETS);
    localparam int SET_LSB   = 2 + WORD_BITS;
    localparam int TAG_LSB   = SET_LSB + SET_BITS;
    localparam int TAG_BITS  = 32 - TAG_LSB;
    // index fields keep one bit for single-word lines or a single set
    localparam int WIDX_W    = (WORD_BITS > 0) ? WORD_BITS : 1;
    localparam int SIDX_W    = (SET_BITS > 0) ? SET_BITS : 1;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SIDX_W-1:0]   set_idx_t;
    typedef logic [WIDX_W-1:0]   word_idx_t;

    tag_t              tags [N_SETS];
    word_t             data [N_SETS][BLOCK_SIZE];
    logic [N_SETS-1:0] valid_q;
    logic [N_SETS-1:0] dirty_q;

    set_idx_t  lk_set;
    set_idx_t  wr_set;
    word_idx_t lk_word;
    word_idx_t wr_widx;
    tag_t      lk_tag;
    tag_t      wr_tag;
    word_t     merged;

    function automatic set_idx_t set_of(word_t a);
        return set_idx_t'((a >> SET_LSB) & word_t'(N_SETS - 1));
    endfunction

    function automatic word_idx_t word_of(word_t a);
        return word_idx_t'((a >> 2) & word_t'(BLOCK_SIZE - 1));
    endfunction

    assign lk_set  = set_of(lookup_addr);
    assign lk_word = word_of(lookup_addr);
    assign lk_tag  = tag_t'(lookup_addr >> TAG_LSB);
    assign wr_set  = set_of(wr_addr);
    assign wr_widx = word_of(wr_addr);
    assign wr_tag  = tag_t'(wr_addr >> TAG_LSB);

    // lookup side
    assign line_valid  = valid_q[lk_set];
    assign line_dirty  = dirty_q[lk_set];
    assign hit         = line_valid && (tags[lk_set] == lk_tag);
    assign hit_word    = data[lk_set][lk_word];
    assign victim_addr = (word_t'(tags[lk_set]) << TAG_LSB) | (word_t'(lk_set) << SET_LSB);

    // byte-lane merge with the stored word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = wr_byte_en[i] ? wr_word[8*i +: 8]
                                             : data[wr_set][wr_widx][8*i +: 8];
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_data_en) begin
            data[wr_set][wr_widx] <= merged;
        end
        if (wr_commit) begin
            tags[wr_set] <= wr_tag;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_commit) begin
            valid_q[wr_set] <= 1'b1;
            dirty_q[wr_set] <= 1'b0;
        end else if (wr_inval) begin
            valid_q[wr_set] <= 1'b0;
            dirty_q[wr_set] <= 1'b0;
        end else if (wr_data_en && valid_q[wr_set]) begin
            // fills go to an invalid line and stay clean
            dirty_q[wr_set] <= 1'b1;
        end
    end

    // a write into a valid line must belong to the tag held there
    assert property (@(posedge CLK) disable iff (!nRST)
        (wr_data_en && valid_q[wr_set]) |-> (tags[wr_set] == wr_tag))
        else $error("data write dirties a line holding another tag");

endmodule

// File: cache_ctrl.sv
/*
 * cache controller
 * lookup, line fill, write-back, flush, reset invalidation, pass-through, counters
 */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
    parameter int    CACHE_SIZE    = 1024,
    parameter int    BLOCK_SIZE    = 2,
    parameter word_t NONCACHE_BASE = 32'hF000_0000
) (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t proc_req,
    output bus_rsp_t proc_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp,
    input  logic     flush,
    output logic     flush_done,
    output count_t   misses,
    output count_t   conflicts,
    output word_t    lookup_addr,
    input  logic     hit,
    input  logic     line_valid,
    input  logic     line_dirty,
    input  word_t    victim_addr,
    input  word_t    hit_word,
    output logic     wr_data_en,
    output logic     wr_commit,
    output logic     wr_inval,
    output word_t    wr_addr,
    output word_t    wr_word,
    output byte_en_t wr_byte_en
);

    localparam int    N_SETS    = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int    WORD_BITS = $clog2(BLOCK_SIZE);
    localparam int    SET_BITS  = $clog2(N_SETS);
    localparam int    SET_LSB   = 2 + WORD_BITS;
    // one extra bit so the counters can mark a final extra cycle
    localparam int    CNT_W     = WORD_BITS + 1;
    localparam int    SCNT_W    = SET_BITS + 1;
    localparam word_t OFF_MASK  = word_t'(4 * BLOCK_SIZE - 1);
    localparam word_t SET_MASK  = word_t'(N_SETS - 1) << SET_LSB;

    cache_state_t      state;
    cache_state_t      next_state;
    logic [CNT_W-1:0]  word_cnt;
    logic [CNT_W-1:0]  next_word_cnt;
    logic [SCNT_W-1:0] set_cnt;
    logic [SCNT_W-1:0] next_set_cnt;
    logic              flush_req;
    count_t            misses_q;
    count_t            conflicts_q;
    logic              count_miss;

    logic  access;
    logic  pass_through;
    logic  flush_pending;
    logic  word_last;
    logic  set_last;
    word_t word_off;
    word_t line_base;
    word_t set_base;
    word_t pt_wdata;

    assign access        = proc_req.ren || proc_req.wen;
    assign pass_through  = proc_req.addr >= NONCACHE_BASE;
    assign flush_pending = flush || flush_req;
    assign word_off      = (word_t'(word_cnt) << 2) & OFF_MASK;
    assign line_base     = proc_req.addr & ~OFF_MASK;
    assign set_base      = (word_t'(set_cnt) << SET_LSB) & SET_MASK;
    assign word_last     = word_cnt == CNT_W'(BLOCK_SIZE - 1);
    assign set_last      = set_cnt == SCNT_W'(N_SETS - 1);

    // writes always go to the line being looked up
    assign wr_addr   = lookup_addr;
    assign misses    = misses_q;
    assign conflicts = conflicts_q;

    always_comb begin
        case (state)
            LOOKUP:           lookup_addr = proc_req.addr;
            WRITEBACK, FETCH: lookup_addr = line_base | word_off;
            default:          lookup_addr = set_base | word_off;
        endcase
    end

    // uncached writes carry zeros outside the enabled lanes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            pt_wdata[8*i +: 8] = proc_req.byte_en[i] ? proc_req.wdata[8*i +: 8] : 8'h00;
        end
    end

    always_comb begin
        next_state      = state;
        next_word_cnt   = word_cnt;
        next_set_cnt    = set_cnt;
        count_miss      = 1'b0;
        proc_rsp.busy   = 1'b1;
        proc_rsp.rdata  = '0;
        mem_req         = '0;
        mem_req.byte_en = '1;
        wr_data_en      = 1'b0;
        wr_commit       = 1'b0;
        wr_inval        = 1'b0;
        wr_word         = mem_rsp.rdata;
        wr_byte_en      = '1;
        flush_done      = 1'b0;

        case (state)
            INIT: begin
                wr_inval     = 1'b1;
                next_set_cnt = set_cnt + 1'b1;
                if (set_last) begin
                    next_set_cnt = '0;
                    next_state   = LOOKUP;
                end
            end
            LOOKUP: begin
                // an uncached transfer in progress finishes before a flush starts
                if (access && pass_through) begin
                    mem_req.ren     = proc_req.ren;
                    mem_req.wen     = proc_req.wen;
                    mem_req.addr    = proc_req.addr;
                    mem_req.wdata   = pt_wdata;
                    mem_req.byte_en = proc_req.byte_en;
                    proc_rsp        = mem_rsp;
                end else if (flush_pending) begin
                    next_state = FLUSH;
                end else if (access && hit) begin
                    proc_rsp.busy  = 1'b0;
                    proc_rsp.rdata = hit_word;
                    if (proc_req.wen) begin
                        wr_data_en = 1'b1;
                        wr_word    = proc_req.wdata;
                        wr_byte_en = proc_req.byte_en;
                    end
                end else if (access) begin
                    count_miss = 1'b1;
                    if (line_valid && line_dirty) begin
                        next_state = WRITEBACK;
                    end else begin
                        // drop the clean victim so the fill lands in an invalid line
                        wr_inval   = 1'b1;
                        next_state = FETCH;
                    end
                end
            end
            WRITEBACK: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = victim_addr | word_off;
                mem_req.wdata = hit_word;
                if (!mem_rsp.busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    if (word_last) begin
                        next_word_cnt = '0;
                        wr_inval      = 1'b1;
                        next_state    = FETCH;
                    end
                end
            end
            FETCH: begin
                if (word_cnt == CNT_W'(BLOCK_SIZE)) begin
                    wr_commit     = 1'b1;
                    next_word_cnt = '0;
                    next_state    = LOOKUP;
                end else begin
                    mem_req.ren  = 1'b1;
                    mem_req.addr = lookup_addr;
                    if (!mem_rsp.busy) begin
                        wr_data_en    = 1'b1;
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            FLUSH: begin
                if (set_cnt == SCNT_W'(N_SETS)) begin
                    flush_done   = 1'b1;
                    next_set_cnt = '0;
                    next_state   = LOOKUP;
                end else if (line_valid && line_dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = victim_addr | word_off;
                    mem_req.wdata = hit_word;
                    if (!mem_rsp.busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                        if (word_last) begin
                            next_word_cnt = '0;
                            wr_inval      = 1'b1;
                            next_set_cnt  = set_cnt + 1'b1;
                        end
                    end
                end else begin
                    wr_inval     = 1'b1;
                    next_set_cnt = set_cnt + 1'b1;
                end
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= INIT;
            word_cnt    <= '0;
            set_cnt     <= '0;
            flush_req   <= 1'b0;
            misses_q    <= '0;
            conflicts_q <= '0;
        end else begin
            state     <= next_state;
            word_cnt  <= next_word_cnt;
            set_cnt   <= next_set_cnt;
            // held until lookup hands over to the flush walk
            flush_req <= flush_pending && !(state == LOOKUP && next_state == FLUSH);
            if (count_miss) begin
                misses_q <= misses_q + 1'b1;
                if (line_valid) begin
                    conflicts_q <= conflicts_q + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({wr_data_en, wr_commit, wr_inval}))
        else $error("more than one array write in a cycle");

    // a flush ends only after a walk over every set
    assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> (state == FLUSH) && $past(state == FLUSH, N_SETS))
        else $error("flush_done outside the end of a full flush walk");

endmodule

// File: l1_cache.sv
/*
 * l1 cache top
 * direct-mapped write-back cache between a processor bus and a memory bus
 */
`timescale 1ns/1ps

module l1_cache import cache_pkg::*; #(
    parameter int    CACHE_SIZE    = 1024,
    parameter int    BLOCK_SIZE    = 2,
    parameter word_t NONCACHE_BASE = 32'hF000_0000
) (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t proc_req,
    output bus_rsp_t proc_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp,
    input  logic     flush,
    output logic     flush_done,
    output count_t   misses,
    output count_t   conflicts
);

    // lookup results
    word_t    lookup_addr;
    logic     hit;
    logic     line_valid;
    logic     line_dirty;
    word_t    victim_addr;
    word_t    hit_word;

    // array write port
    logic     wr_data_en;
    logic     wr_commit;
    logic     wr_inval;
    word_t    wr_addr;
    word_t    wr_word;
    byte_en_t wr_byte_en;

    cache_ctrl #(
        .CACHE_SIZE   (CACHE_SIZE),
        .BLOCK_SIZE   (BLOCK_SIZE),
        .NONCACHE_BASE(NONCACHE_BASE)
    ) u_cache_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done),
        .misses     (misses),
        .conflicts  (conflicts),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .line_valid (line_valid),
        .line_dirty (line_dirty),
        .victim_addr(victim_addr),
        .hit_word   (hit_word),
        .wr_data_en (wr_data_en),
        .wr_commit  (wr_commit),
        .wr_inval   (wr_inval),
        .wr_addr    (wr_addr),
        .wr_word    (wr_word),
        .wr_byte_en (wr_byte_en)
    );

    line_array #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE)
    ) u_line_array (
        .CLK        (CLK),
        .nRST       (nRST),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .line_valid (line_valid),
        .line_dirty (line_dirty),
        .victim_addr(victim_addr),
        .hit_word   (hit_word),
        .wr_data_en (wr_data_en),
        .wr_commit  (wr_commit),
        .wr_inval   (wr_inval),
        .wr_addr    (wr_addr),
        .wr_word    (wr_word),
        .wr_byte_en (wr_byte_en)
    );

endmodule

// File: tb_l1_cache_tasks.svh
/*
 * testbench models and checks
 * reference memory, cache-state model and typed compare tasks
 */
`ifndef TB_L1_CACHE_TASKS_SVH
`define TB_L1_CACHE_TASKS_SVH

// coherent processor view, cacheable words first, then the uncached window
word_t  ref_mem [512];
word_t  mdl_tag [N_SETS];
logic   mdl_valid [N_SETS];
logic   mdl_dirty [N_SETS];
count_t exp_misses;
count_t exp_conflicts;
int     checks;
int     errors;

function automatic int mem_index(word_t a);
    return int'({a[31], a[9:2]});
endfunction

function automatic word_t index_addr(int i);
    return (i >= 256) ? (NONCACHE_BASE | word_t'((i - 256) << 2)) : word_t'(i << 2);
endfunction

function automatic word_t fill_value(word_t a);
    return (a * 32'h9E37_79B9) ^ 32'h5A3C_96E1;
endfunction

function automatic word_t merge_lanes(word_t old_w, word_t new_w, byte_en_t be);
    word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
            res[8*i +: 8] = new_w[8*i +: 8];
        end
    end
    return res;
endfunction

// direct-mapped lookup with write allocate
task automatic model_access(word_t a, logic wr);
    int    s;
    word_t t;
    s = int'((a / (4 * BLOCK_SIZE)) % N_SETS);
    t = a / CACHE_SIZE;
    if (a >= NONCACHE_BASE) begin
        return;
    end
    if (!mdl_valid[s] || mdl_tag[s] != t) begin
        exp_misses = exp_misses + 1;
        if (mdl_valid[s]) begin
            exp_conflicts = exp_conflicts + 1;
        end
        mdl_valid[s] = 1'b1;
        mdl_tag[s]   = t;
        mdl_dirty[s] = 1'b0;
    end
    if (wr) begin
        mdl_dirty[s] = 1'b1;
    end
endtask

// returns how many lines need a write-back
function automatic int model_flush();
    int n;
    n = 0;
    for (int s = 0; s < N_SETS; s++) begin
        if (mdl_valid[s] && mdl_dirty[s]) begin
            n++;
        end
        mdl_valid[s] = 1'b0;
        mdl_dirty[s] = 1'b0;
    end
    return n;
endfunction

task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_count(string name, count_t exp, count_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
endtask

`endif

// File: tb_l1_cache.sv
/*
 * l1 cache testbench
 * random traffic against a memory model and a reference model of the cache
 */
`timescale 1ns/1ps

module tb_l1_cache import cache_pkg::*; ();

    localparam int    CACHE_SIZE     = 256;
    localparam int    BLOCK_SIZE     = 4;
    localparam word_t NONCACHE_BASE  = 32'hF000_0000;
    localparam int    N_SETS         = CACHE_SIZE / (4 * BLOCK_SIZE);
    localparam int    PERIOD         = 100;
    localparam int    RESET_CYCLES   = 16;
    localparam int    N_OPS          = 48;
    localparam int    TOTAL_REQS     = 6 * N_OPS + 64 + 32;
    // write-back plus fill, up to four cycles per word, plus access overhead
    localparam int    MISS_BOUND     = 2 * BLOCK_SIZE * 4 + 8;
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + (TOTAL_REQS + N_SETS) * MISS_BOUND;

    logic     CLK;
    logic     nRST;
    logic     flush;
    logic     flush_done;
    bus_req_t proc_req;
    bus_rsp_t proc_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    count_t   misses;
    count_t   conflicts;

    // memory model state
    word_t mem_model [512];
    logic  mem_busy   = 1'b0;
    int    wait_left  = 0;
    int    mem_writes = 0;

    byte_en_t be_list [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
    int       tests_run;
    int       tests_failed;
    int       errors_at_start;

    `include "tb_l1_cache_tasks.svh"

    l1_cache #(
        .CACHE_SIZE   (CACHE_SIZE),
        .BLOCK_SIZE   (BLOCK_SIZE),
        .NONCACHE_BASE(NONCACHE_BASE)
    ) u_l1_cache (
        .CLK       (CLK),
        .nRST      (nRST),
        .proc_req  (proc_req),
        .proc_rsp  (proc_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .flush     (flush),
        .flush_done(flush_done),
        .misses    (misses),
        .conflicts (conflicts)
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    assign mem_rsp = {mem_busy, mem_model[mem_index(mem_req.addr)]};

    // a transfer completes on an edge with busy low, then the next delay is drawn
    always @(posedge CLK) begin
        if (mem_req.ren || mem_req.wen) begin
            if (!mem_busy) begin
                if (mem_req.wen) begin
                    mem_model[mem_index(mem_req.addr)] <= mem_req.wdata;
                    mem_writes <= mem_writes + 1;
                end
                wait_left <= int'($urandom_range(3, 0));
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(negedge CLK) begin
        mem_busy = wait_left != 0;
    end

    initial begin
        #(PERIOD * TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    function automatic word_t rand_addr();
        return word_t'($urandom_range(255, 0)) << 2;
    endfunction

    function automatic byte_en_t rand_be();
        return be_list[$urandom_range(6, 0)];
    endfunction

    // hold the request until busy drops, sampled a quarter period after the drive edge
    task automatic bus_access(input logic wr, input word_t addr, input word_t wdata,
                              input byte_en_t be, output word_t rdata);
        @(negedge CLK);
        proc_req.ren     = !wr;
        proc_req.wen     = wr;
        proc_req.addr    = addr;
        proc_req.wdata   = wdata;
        proc_req.byte_en = be;
        #(PERIOD / 4);
        while (proc_rsp.busy) begin
            @(negedge CLK);
            #(PERIOD / 4);
        end
        rdata = proc_rsp.rdata;
        @(negedge CLK);
        proc_req = '0;
    endtask

    task automatic read_check(string name, word_t addr);
        word_t rd;
        bus_access(1'b0, addr, '0, 4'hF, rd);
        model_access(addr, 1'b0);
        check_word($sformatf("%s @%h", name, addr), ref_mem[mem_index(addr)], rd);
    endtask

    task automatic write_word(word_t addr, word_t wdata, byte_en_t be);
        word_t rd;
        int    idx;
        idx = mem_index(addr);
        bus_access(1'b1, addr, wdata, be, rd);
        model_access(addr, 1'b1);
        // uncached writes land with unused lanes zeroed
        if (addr >= NONCACHE_BASE) begin
            ref_mem[idx] = merge_lanes('0, wdata, be);
        end else begin
            ref_mem[idx] = merge_lanes(ref_mem[idx], wdata, be);
        end
    endtask

    task automatic check_counters(string name);
        check_count({name, " misses"}, exp_misses, misses);
        check_count({name, " conflicts"}, exp_conflicts, conflicts);
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-12s pass", name);
        end else begin
            tests_failed++;
            $display("test %-12s FAIL with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic run_flush();
        word_t written [$];
        word_t a;
        int    dirty_lines;
        int    writes_before;
        repeat (N_OPS) begin
            a = rand_addr();
            write_word(a, $urandom(), rand_be());
            written.push_back(a);
        end
        writes_before = mem_writes;
        dirty_lines   = model_flush();
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        while (!flush_done) begin
            @(negedge CLK);
        end
        @(negedge CLK);
        // done is a single-cycle pulse
        checks++;
        if (flush_done) begin
            errors++;
            $display("flush_done stayed high for more than one cycle");
        end
        check_count("flush write-backs", count_t'(dirty_lines * BLOCK_SIZE),
                    count_t'(mem_writes - writes_before));
        for (int i = 0; i < 256; i++) begin
            check_word($sformatf("flush mem @%h", index_addr(i)), ref_mem[i], mem_model[i]);
        end
        foreach (written[i]) begin
            read_check("after flush", written[i]);
        end
        check_counters("flush");
    endtask

    initial begin
        word_t written [$];
        word_t a;
        word_t d;
        byte_en_t be;
        int s;
        int w;

        void'($urandom(32'he296528f));
        nRST          = 1'b0;
        flush         = 1'b0;
        proc_req      = '0;
        exp_misses    = '0;
        exp_conflicts = '0;
        checks        = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_at_start = 0;
        for (int i = 0; i < 512; i++) begin
            ref_mem[i]    = fill_value(index_addr(i));
            mem_model[i] <= fill_value(index_addr(i));
        end
        for (int i = 0; i < N_SETS; i++) begin
            mdl_valid[i] = 1'b0;
            mdl_dirty[i] = 1'b0;
            mdl_tag[i]   = '0;
        end
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;

        repeat (N_OPS) read_check("reads", rand_addr());
        check_counters("reads");
        finish_test("reads");

        repeat (N_OPS) begin
            a = rand_addr();
            write_word(a, $urandom(), rand_be());
            written.push_back(a);
        end
        foreach (written[i]) begin
            read_check("writes", written[i]);
        end
        check_counters("writes");
        finish_test("writes");

        // four tags in one set force dirty evictions
        repeat (8) begin
            s = $urandom_range(N_SETS - 1, 0);
            w = $urandom_range(BLOCK_SIZE - 1, 0);
            for (int t = 0; t < 4; t++) begin
                write_word(word_t'(t * CACHE_SIZE + s * 4 * BLOCK_SIZE + w * 4),
                           $urandom(), rand_be());
            end
            for (int t = 0; t < 4; t++) begin
                read_check("eviction", word_t'(t * CACHE_SIZE + s * 4 * BLOCK_SIZE + w * 4));
            end
        end
        check_counters("eviction");
        finish_test("eviction");

        repeat (16) begin
            a  = NONCACHE_BASE | (word_t'($urandom_range(15, 0)) << 2);
            d  = $urandom();
            be = rand_be();
            write_word(a, d, be);
            check_word($sformatf("uncached write @%h", a), merge_lanes('0, d, be),
                       mem_model[mem_index(a)]);
        end
        repeat (16) read_check("uncached read", NONCACHE_BASE | (rand_addr() & 32'h3C));
        check_counters("uncached");
        finish_test("uncached");

        run_flush();
        finish_test("flush");

        $display("summary %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
cache_pkg.sv
line_array.sv
cache_ctrl.sv
l1_cache.sv
tb_l1_cache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_l1_cache
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
